/* common/lcd_pkg.sv */
/*
 * Shared constants and types for the RGB LCD clock display.
 * Panel timing tables, strap decode, colours and text layout.
 */
package lcd_pkg;

    //****************************************
    // Panel identification
    //****************************************
    localparam logic [15:0] ID_4342      = 16'h4342;  // 4.3 inch 480x272
    localparam logic [15:0] ID_7084      = 16'h7084;  // 7 inch 800x480
    localparam int          PROBE_CYCLES = 16;        // Reset hold before strap sample

    typedef enum logic {
        PANEL_43 = 1'b0,
        PANEL_70 = 1'b1
    } panel_sel_t;

    // Timing sets, indexed by panel_sel_t
    localparam logic [10:0] H_SYNC  [2] = '{11'd41,  11'd128};
    localparam logic [10:0] H_BACK  [2] = '{11'd2,   11'd88};
    localparam logic [10:0] H_DISP  [2] = '{11'd480, 11'd800};
    localparam logic [10:0] H_TOTAL [2] = '{11'd525, 11'd1056};
    localparam logic [10:0] V_SYNC  [2] = '{11'd10,  11'd2};
    localparam logic [10:0] V_BACK  [2] = '{11'd2,   11'd33};
    localparam logic [10:0] V_DISP  [2] = '{11'd272, 11'd480};
    localparam logic [10:0] V_TOTAL [2] = '{11'd286, 11'd525};
    localparam logic [2:0]  PCLK_DIV [2] = '{3'd4, 3'd2};  // sys_clk cycles per pixel

    //****************************************
    // RGB pin word, pixel and strap views
    //****************************************
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_pix_t;

    typedef struct packed {
        logic       m0;      // R[7]
        logic [6:0] r_low;
        logic       m1;      // G[7]
        logic [6:0] g_low;
        logic       m2;      // B[7]
        logic [6:0] b_low;
    } rgb_strap_t;

    typedef union packed {
        rgb_pix_t   pix;
        rgb_strap_t strap;
    } rgb_word_t;

    // Strap code {M2,M1,M0} to panel ID, only code 1 is the 7 inch panel
    localparam logic [15:0] STRAP_TO_ID [8] = '{ID_4342, ID_7084, ID_4342, ID_4342,
                                                ID_4342, ID_4342, ID_4342, ID_4342};

    //****************************************
    // Text layout and glyphs
    //****************************************
    localparam int TEXT_X0     = 16;
    localparam int TEXT_Y0     = 16;
    localparam int GLYPH_SCALE = 2;   // Each font pixel drawn 2x2
    localparam int TEXT_LEN    = 19;  // "20YY-MM-DD HH:MM:SS"
    localparam int TEXT_W      = TEXT_LEN * 8 * GLYPH_SCALE;
    localparam int TEXT_H      = 8 * GLYPH_SCALE;
    localparam int FONT_DEPTH  = 13 * 8;  // 13 glyphs of 8 rows

    typedef logic [3:0] glyph_t;  // 0..9 digits
    localparam glyph_t GLYPH_DASH  = 4'd10;
    localparam glyph_t GLYPH_COLON = 4'd11;
    localparam glyph_t GLYPH_BLANK = 4'd12;

    localparam rgb_word_t FG_COLOR   = 24'hFFFFFF;  // White text
    localparam rgb_word_t BG_COLOR   = 24'h0000FF;  // Blue field
    localparam int        RENDER_LAT = 2;           // Pixel enables through render

endpackage

/* verilog/panel_probe.sv */
`timescale 1ns/10ps
/*
 * Panel detect after reset. Holds the panel in reset with the RGB pins
 * released, then samples the M2..M0 straps and fixes the timing set.
 */
module panel_probe (
    input  logic                clk,
    input  logic                rst_n,
    input  lcd_pkg::rgb_word_t  lcd_rgb_in,   // Straps on R7 G7 B7
    output lcd_pkg::panel_sel_t panel_sel,
    output logic                probe_done,
    output logic                lcd_rst,      // Panel reset, active low
    output logic                lcd_rgb_oe    // Pad drive enable
);
    import lcd_pkg::*;

    logic [4:0]  hold_cnt;    // Cycles spent holding the panel
    logic [2:0]  strap_code;  // {M2, M1, M0}
    logic [15:0] strap_id;

    assign strap_code = {lcd_rgb_in.strap.m2, lcd_rgb_in.strap.m1, lcd_rgb_in.strap.m0};
    assign strap_id   = STRAP_TO_ID[strap_code];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_cnt   <= '0;
            probe_done <= 1'b0;
            panel_sel  <= PANEL_43;
        end else if (!probe_done) begin
            if (hold_cnt == 5'(PROBE_CYCLES - 1)) begin
                probe_done <= 1'b1;  // Sample once, never again
                // Unknown IDs fall back to the 4.3 inch set
                panel_sel  <= (strap_id == ID_7084) ? PANEL_70 : PANEL_43;
            end
            hold_cnt <= hold_cnt + 5'd1;
        end
    end

    // Panel leaves reset and pads turn around together with probe_done
    assign lcd_rst    = probe_done;
    assign lcd_rgb_oe = probe_done;

endmodule

/* lcd_timing/lcd_timing.sv */
`timescale 1ns/10ps
/*
 * Pixel-enable divider and raster counters for the selected panel.
 * Gives sync, display enable and the position inside the active area.
 */
module lcd_timing (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                probe_done,
    input  lcd_pkg::panel_sel_t panel_sel,
    output logic                pix_en,       // One sys_clk cycle per pixel
    output logic                hs,           // Active low
    output logic                vs,           // Active low
    output logic                de,
    output logic                frame_start,  // pix_en at raster (0,0)
    output logic [10:0]         pixel_xpos,
    output logic [10:0]         pixel_ypos
);
    import lcd_pkg::*;

    logic [2:0]  div_cnt;    // Phase within one pixel period
    logic [10:0] h_cnt;      // Sync starts at 0
    logic [10:0] v_cnt;
    logic [10:0] h_act_beg;
    logic [10:0] h_act_end;
    logic [10:0] v_act_beg;
    logic [10:0] v_act_end;
    logic        h_last;
    logic        v_last;
    logic        h_act;
    logic        v_act;

    // Active window edges for the fitted panel
    assign h_act_beg = H_SYNC[panel_sel] + H_BACK[panel_sel];
    assign h_act_end = h_act_beg + H_DISP[panel_sel];
    assign v_act_beg = V_SYNC[panel_sel] + V_BACK[panel_sel];
    assign v_act_end = v_act_beg + V_DISP[panel_sel];

    //****************************************
    // Pixel enable divider
    //****************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            pix_en  <= 1'b0;
        end else begin
            pix_en <= probe_done && (div_cnt == 3'd0);  // First one right after probe
            if (!probe_done || div_cnt == PCLK_DIV[panel_sel] - 3'd1)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 3'd1;
        end
    end

    //****************************************
    // Raster counters
    //****************************************
    assign h_last = (h_cnt == H_TOTAL[panel_sel] - 11'd1);
    assign v_last = (v_cnt == V_TOTAL[panel_sel] - 11'd1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pix_en) begin
            if (h_last) begin
                h_cnt <= '0;
                v_cnt <= v_last ? 11'd0 : v_cnt + 11'd1;  // Wrap at frame end
            end else begin
                h_cnt <= h_cnt + 11'd1;
            end
        end
    end

    assign hs          = (h_cnt >= H_SYNC[panel_sel]);  // Low during sync pulse
    assign vs          = (v_cnt >= V_SYNC[panel_sel]);
    assign h_act       = (h_cnt >= h_act_beg) && (h_cnt < h_act_end);
    assign v_act       = (v_cnt >= v_act_beg) && (v_cnt < v_act_end);
    assign de          = h_act && v_act;
    assign frame_start = pix_en && (h_cnt == 11'd0) && (v_cnt == 11'd0);

    // Position from the top-left visible pixel
    assign pixel_xpos  = de ? h_cnt - h_act_beg : 11'd0;
    assign pixel_ypos  = de ? v_cnt - v_act_beg : 11'd0;

endmodule

/* time_text/time_text_render.sv */
`timescale 1ns/10ps
/*
 * Draws "20YY-MM-DD HH:MM:SS" from BCD time in scaled 8x8 glyphs.
 * Two pixel-enable stages, time frozen per frame at frame_start.
 */
module time_text_render (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pix_en,
    input  logic               frame_start,
    input  logic               de,
    input  logic [10:0]        pixel_xpos,
    input  logic [10:0]        pixel_ypos,
    input  logic [7:0]         sec,
    input  logic [7:0]         min,
    input  logic [7:0]         hour,
    input  logic [7:0]         day,
    input  logic [7:0]         mon,
    input  logic [7:0]         year,
    output lcd_pkg::rgb_word_t pixel_data
);
    import lcd_pkg::*;

    logic [7:0]  snap_sec;    // Frame snapshot, no tearing mid-frame
    logic [7:0]  snap_min;
    logic [7:0]  snap_hour;
    logic [7:0]  snap_day;
    logic [7:0]  snap_mon;
    logic [7:0]  snap_year;
    logic [10:0] rel_x;
    logic [10:0] rel_y;
    logic [10:0] cell_x;      // Position in font pixels
    logic [10:0] cell_y;
    logic [4:0]  slot;        // Character index 0..18
    logic        in_box;
    glyph_t      code;
    logic        s1_in_box;
    logic [6:0]  s1_addr;     // {glyph, row}
    logic [2:0]  s1_col;
    logic [7:0]  font_row;
    logic [7:0]  font_rom [FONT_DEPTH];

    initial $readmemh("time_text/font_8x8.hex", font_rom);

    always_ff @(posedge clk) begin
        if (frame_start) begin
            snap_sec  <= sec;
            snap_min  <= min;
            snap_hour <= hour;
            snap_day  <= day;
            snap_mon  <= mon;
            snap_year <= year;
        end
    end

    //****************************************
    // Stage 1, position to glyph address
    //****************************************
    assign rel_x  = pixel_xpos - 11'(TEXT_X0);
    assign rel_y  = pixel_ypos - 11'(TEXT_Y0);
    assign cell_x = rel_x / 11'(GLYPH_SCALE);
    assign cell_y = rel_y / 11'(GLYPH_SCALE);
    assign slot   = cell_x[7:3];
    assign in_box = de && (pixel_xpos >= TEXT_X0) && (rel_x < TEXT_W)
                    && (pixel_ypos >= TEXT_Y0) && (rel_y < TEXT_H);

    always_comb begin
        case (slot)
            5'd0:    code = 4'd2;               // Century is fixed
            5'd1:    code = 4'd0;
            5'd2:    code = snap_year[7:4];
            5'd3:    code = snap_year[3:0];
            5'd4:    code = GLYPH_DASH;
            5'd5:    code = snap_mon[7:4];
            5'd6:    code = snap_mon[3:0];
            5'd7:    code = GLYPH_DASH;
            5'd8:    code = snap_day[7:4];
            5'd9:    code = snap_day[3:0];
            5'd11:   code = snap_hour[7:4];
            5'd12:   code = snap_hour[3:0];
            5'd13:   code = GLYPH_COLON;
            5'd14:   code = snap_min[7:4];
            5'd15:   code = snap_min[3:0];
            5'd16:   code = GLYPH_COLON;
            5'd17:   code = snap_sec[7:4];
            5'd18:   code = snap_sec[3:0];
            default: code = GLYPH_BLANK;       // Gap between date and time
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_in_box <= 1'b0;
        end else if (pix_en) begin
            s1_in_box <= in_box;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_en) begin
            s1_addr <= {code, cell_y[2:0]};
            s1_col  <= cell_x[2:0];
        end
    end

    //****************************************
    // Stage 2, font lookup and colour
    //****************************************
    assign font_row = font_rom[s1_addr];

    always_ff @(posedge clk) begin
        if (pix_en)
            pixel_data <= (s1_in_box && font_row[3'd7 - s1_col]) ? FG_COLOR : BG_COLOR;
    end

endmodule

/* verilog/lcd_output_stage.sv */
`timescale 1ns/10ps
/*
 * Panel pin stage. Lines sync and enable up with the render pipeline,
 * blanks RGB outside the active area and builds the pixel clock.
 */
module lcd_output_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pix_en,
    input  logic               probe_done,
    input  logic               hs,
    input  logic               vs,
    input  logic               de,
    input  lcd_pkg::rgb_word_t pixel_data,
    output logic               lcd_hs,
    output logic               lcd_vs,
    output logic               lcd_de,
    output logic               lcd_bl,
    output logic               lcd_clk,
    output lcd_pkg::rgb_word_t lcd_rgb
);
    import lcd_pkg::*;

    logic [RENDER_LAT-1:0] hs_pipe;  // Matches render latency
    logic [RENDER_LAT-1:0] vs_pipe;
    logic [RENDER_LAT-1:0] de_pipe;
    logic [2:0]            ph_cnt;   // sys_clk cycles since last pix_en
    logic [2:0]            per_len;  // Measured pixel period

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_pipe <= '0;
            vs_pipe <= '0;
            de_pipe <= '0;
        end else if (pix_en) begin
            hs_pipe <= {hs_pipe[RENDER_LAT-2:0], hs};
            vs_pipe <= {vs_pipe[RENDER_LAT-2:0], vs};
            de_pipe <= {de_pipe[RENDER_LAT-2:0], de};
        end
    end

    // Final pin register adds one sys_clk
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lcd_hs  <= 1'b0;
            lcd_vs  <= 1'b0;
            lcd_de  <= 1'b0;
            lcd_rgb <= '0;
        end else begin
            lcd_hs  <= hs_pipe[RENDER_LAT-1];
            lcd_vs  <= vs_pipe[RENDER_LAT-1];
            lcd_de  <= de_pipe[RENDER_LAT-1];
            lcd_rgb <= de_pipe[RENDER_LAT-1] ? pixel_data : '0;  // Blank in porches
        end
    end

    //****************************************
    // Pixel clock from the pix_en phase
    //****************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ph_cnt  <= '0;
            per_len <= '0;
            lcd_clk <= 1'b0;
        end else if (pix_en) begin
            per_len <= ph_cnt;  // Zero until one full period has passed
            ph_cnt  <= 3'd1;
            lcd_clk <= 1'b1;    // Rising edge follows pix_en
        end else begin
            if (ph_cnt != 3'd0 && ph_cnt != 3'd7)
                ph_cnt <= ph_cnt + 3'd1;
            lcd_clk <= (ph_cnt < (per_len >> 1));  // High for half the period
        end
    end

    assign lcd_bl = probe_done;  // Backlight on once the panel is probed

endmodule

/* verilog/lcd_rgb_char.sv */
`timescale 1ns/10ps
/*
 * RGB LCD clock display top. Probes the panel, runs its timing and
 * shows the BCD date and time. Pad tristate lives in the FPGA wrapper.
 */
module lcd_rgb_char (
    input  logic               sys_clk,
    input  logic               rst_n,
    input  logic [7:0]         sec,         // BCD time
    input  logic [7:0]         min,
    input  logic [7:0]         hour,
    input  logic [7:0]         day,
    input  logic [7:0]         mon,
    input  logic [7:0]         year,
    input  lcd_pkg::rgb_word_t lcd_rgb_in,  // Pad input, straps at reset
    output lcd_pkg::rgb_word_t lcd_rgb,
    output logic               lcd_rgb_oe,
    output logic               lcd_hs,
    output logic               lcd_vs,
    output logic               lcd_de,
    output logic               lcd_bl,      // Backlight on after probe
    output logic               lcd_clk,
    output logic               lcd_rst
);
    import lcd_pkg::*;

    panel_sel_t  panel_sel;
    logic        probe_done;
    logic        pix_en;
    logic        hs;
    logic        vs;
    logic        de;
    logic        frame_start;
    logic [10:0] pixel_xpos;
    logic [10:0] pixel_ypos;
    rgb_word_t   pixel_data;

    //****************************************
    // Panel detect
    //****************************************
    panel_probe u_panel_probe (
        .clk        (sys_clk),
        .rst_n      (rst_n),
        .lcd_rgb_in (lcd_rgb_in),
        .panel_sel  (panel_sel),
        .probe_done (probe_done),
        .lcd_rst    (lcd_rst),
        .lcd_rgb_oe (lcd_rgb_oe)
    );

    lcd_timing u_lcd_timing (
        .clk         (sys_clk),
        .rst_n       (rst_n),
        .probe_done  (probe_done),
        .panel_sel   (panel_sel),
        .pix_en      (pix_en),
        .hs          (hs),
        .vs          (vs),
        .de          (de),
        .frame_start (frame_start),
        .pixel_xpos  (pixel_xpos),
        .pixel_ypos  (pixel_ypos)
    );

    // Text renderer, two pixel enables deep
    time_text_render u_time_text_render (
        .clk         (sys_clk),
        .rst_n       (rst_n),
        .pix_en      (pix_en),
        .frame_start (frame_start),
        .de          (de),
        .pixel_xpos  (pixel_xpos),
        .pixel_ypos  (pixel_ypos),
        .sec         (sec),
        .min         (min),
        .hour        (hour),
        .day         (day),
        .mon         (mon),
        .year        (year),
        .pixel_data  (pixel_data)
    );

    lcd_output_stage u_lcd_output_stage (
        .clk        (sys_clk),
        .rst_n      (rst_n),
        .pix_en     (pix_en),
        .probe_done (probe_done),
        .hs         (hs),
        .vs         (vs),
        .de         (de),
        .pixel_data (pixel_data),
        .lcd_hs     (lcd_hs),
        .lcd_vs     (lcd_vs),
        .lcd_de     (lcd_de),
        .lcd_bl     (lcd_bl),
        .lcd_clk    (lcd_clk),
        .lcd_rgb    (lcd_rgb)
    );

endmodule

/* testbench/tb_frame_checker.sv */
`timescale 1ns/10ps
/*
 * Frame checker on the top-level pins. Checks probe timing, raster
 * geometry, sync widths, blanking and every pixel of the clock text.
 */
module tb_frame_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [7:0]         sec,
    input  logic [7:0]         min,
    input  logic [7:0]         hour,
    input  logic [7:0]         day,
    input  logic [7:0]         mon,
    input  logic [7:0]         year,
    input  lcd_pkg::rgb_word_t lcd_rgb_in,
    input  lcd_pkg::rgb_word_t lcd_rgb,
    input  logic               lcd_rgb_oe,
    input  logic               lcd_hs,
    input  logic               lcd_vs,
    input  logic               lcd_de,
    input  logic               lcd_bl,
    input  logic               lcd_clk,
    input  logic               lcd_rst,
    output logic               check_failed
);
    import lcd_pkg::*;

    logic [7:0] font [FONT_DEPTH];   // Reference copy of the glyphs
    logic [3:0] text_codes [TEXT_LEN];  // Glyphs of the current frame
    panel_sel_t exp_panel;
    int         div;                 // sys_clk cycles per pixel
    int         probe_cnt;
    int         de_run;              // Cycles in the current de run
    int         line_cnt;            // Display lines this frame
    int         hs_low, hs_per, vs_low, vs_per, clk_per;
    int         px, py;
    logic       seen_probe, hs_seen, vs_seen, clk_seen, frame_valid;
    logic       prev_de, prev_hs, prev_vs, prev_clk;
    rgb_word_t  exp_pix;

    initial begin
        check_failed = 1'b0;
        $readmemh("time_text/font_8x8.hex", font);
    end

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        check_failed = 1'b1;
    endtask

    // Fill the glyph row from a text template, letters name the BCD field
    task automatic capture_time;
        string      tmpl;
        byte        c;
        logic [7:0] val;
        tmpl = "20yy-MM-dd hh:mm:ss";
        for (int i = 0; i < TEXT_LEN; i++) begin
            c = tmpl[i];
            case (c)
                "y":     val = year;
                "M":     val = mon;
                "d":     val = day;
                "h":     val = hour;
                "m":     val = min;
                "s":     val = sec;
                default: val = 8'd0;
            endcase
            if (c == "-")
                text_codes[i] = 4'd10;
            else if (c == ":")
                text_codes[i] = 4'd11;
            else if (c == " ")
                text_codes[i] = 4'd12;
            else if (c >= "0" && c <= "9")
                text_codes[i] = 4'(c - "0");
            else if (i < TEXT_LEN - 1 && tmpl[i+1] == c)
                text_codes[i] = val[7:4];  // Tens digit first
            else
                text_codes[i] = val[3:0];
        end
    endtask

    function automatic rgb_word_t expected_pixel(input int x, input int y);
        int         cx, cy, slot;
        logic [7:0] row_bits;
        if (x < TEXT_X0 || x >= TEXT_X0 + TEXT_LEN * 8 * GLYPH_SCALE ||
            y < TEXT_Y0 || y >= TEXT_Y0 + 8 * GLYPH_SCALE)
            return BG_COLOR;
        cx       = (x - TEXT_X0) / GLYPH_SCALE;
        cy       = (y - TEXT_Y0) / GLYPH_SCALE;
        slot     = cx / 8;
        row_bits = font[int'(text_codes[slot]) * 8 + cy];
        return row_bits[7 - (cx % 8)] ? FG_COLOR : BG_COLOR;
    endfunction

    //****************************************
    // Per-cycle checks
    //****************************************
    always @(posedge clk) begin
        if (!rst_n) begin
            probe_cnt   = 0;
            seen_probe  = 1'b0;
            hs_seen     = 1'b0;
            vs_seen     = 1'b0;
            clk_seen    = 1'b0;
            frame_valid = 1'b0;
            de_run      = 0;
            line_cnt    = 0;
            prev_de     = 1'b0;
            prev_hs     = 1'b0;
            prev_vs     = 1'b0;
            prev_clk    = 1'b0;
        end else begin
            assert (lcd_rgb_oe == lcd_rst) else report("probe_oe", lcd_rst, lcd_rgb_oe);
            assert (lcd_bl == lcd_rst) else report("probe_bl", lcd_rst, lcd_bl);
            if (!lcd_rst) begin
                assert (!lcd_de) else report("de_before_probe", 0, lcd_de);
                probe_cnt++;
            end else if (!seen_probe) begin
                assert (probe_cnt == PROBE_CYCLES)
                    else report("probe_cycles", PROBE_CYCLES, probe_cnt);
                seen_probe = 1'b1;
                exp_panel  = ({lcd_rgb_in.strap.m2, lcd_rgb_in.strap.m1,
                               lcd_rgb_in.strap.m0} == 3'd1) ? PANEL_70 : PANEL_43;
                div        = int'(PCLK_DIV[exp_panel]);
                capture_time();  // First frame starts right at probe end
                frame_valid = 1'b1;
                line_cnt    = 0;
            end
            if (seen_probe) begin
                if (!lcd_de)
                    assert (lcd_rgb == 0) else report("blanking", 0, lcd_rgb);
                if (lcd_de) begin
                    if (de_run % div == 0) begin  // First cycle of each pixel
                        px      = de_run / div;
                        py      = line_cnt;
                        exp_pix = expected_pixel(px, py);
                        assert (lcd_rgb == exp_pix)
                            else report($sformatf("text_pixel x%0d y%0d", px, py),
                                        exp_pix, lcd_rgb);
                    end
                    de_run++;
                end else if (prev_de) begin
                    assert (de_run == int'(H_DISP[exp_panel]) * div)
                        else report("line_width", int'(H_DISP[exp_panel]) * div, de_run);
                    de_run = 0;
                    line_cnt++;
                end
                // Horizontal sync
                if (prev_hs && !lcd_hs) begin
                    if (hs_seen)
                        assert (hs_per == int'(H_TOTAL[exp_panel]) * div)
                            else report("hs_period", int'(H_TOTAL[exp_panel]) * div, hs_per);
                    hs_seen = 1'b1;
                    hs_per  = 0;
                    hs_low  = 0;
                end
                if (!prev_hs && lcd_hs && hs_seen)
                    assert (hs_low == int'(H_SYNC[exp_panel]) * div)
                        else report("hs_width", int'(H_SYNC[exp_panel]) * div, hs_low);
                // Vertical sync, also the frame boundary
                if (prev_vs && !lcd_vs) begin
                    if (vs_seen)
                        assert (vs_per == int'(V_TOTAL[exp_panel]) *
                                          int'(H_TOTAL[exp_panel]) * div)
                            else report("vs_period", int'(V_TOTAL[exp_panel]) *
                                        int'(H_TOTAL[exp_panel]) * div, vs_per);
                    if (frame_valid)
                        assert (line_cnt == int'(V_DISP[exp_panel]))
                            else report("frame_lines", V_DISP[exp_panel], line_cnt);
                    vs_seen     = 1'b1;
                    vs_per      = 0;
                    vs_low      = 0;
                    line_cnt    = 0;
                    frame_valid = 1'b1;
                    capture_time();
                end
                if (!prev_vs && lcd_vs && vs_seen)
                    assert (vs_low == int'(V_SYNC[exp_panel]) * int'(H_TOTAL[exp_panel]) * div)
                        else report("vs_width", int'(V_SYNC[exp_panel]) *
                                    int'(H_TOTAL[exp_panel]) * div, vs_low);
                // Pixel clock period, rise to rise
                if (!prev_clk && lcd_clk) begin
                    if (clk_seen)
                        assert (clk_per == div) else report("lcd_clk_period", div, clk_per);
                    clk_seen = 1'b1;
                    clk_per  = 0;
                end
                hs_per++;
                vs_per++;
                clk_per++;
                if (!lcd_hs) hs_low++;
                if (!lcd_vs) vs_low++;
            end
            prev_de  = lcd_de;
            prev_hs  = lcd_hs;
            prev_vs  = lcd_vs;
            prev_clk = lcd_clk;
        end
    end

endmodule

/* testbench/tb_lcd_rgb_char.sv */
`timescale 1ns/10ps
/*
 * Testbench for the LCD clock display. Runs two frames on each panel
 * strap setting, stepping the BCD time mid-frame from an LFSR.
 */
module tb_lcd_rgb_char;
    import lcd_pkg::*;

    localparam int     CLK_PERIOD = 100;
    localparam longint FRAME_43   = longint'(H_TOTAL[0]) * V_TOTAL[0] * PCLK_DIV[0];
    localparam longint FRAME_70   = longint'(H_TOTAL[1]) * V_TOTAL[1] * PCLK_DIV[1];
    // 2.5x of two frames per panel
    localparam longint WATCHDOG_NS = (2 * FRAME_43 + 2 * FRAME_70) * CLK_PERIOD * 5 / 2;

    logic        sys_clk;
    logic        rst_n;
    logic [7:0]  sec;
    logic [7:0]  min;
    logic [7:0]  hour;
    logic [7:0]  day;
    logic [7:0]  mon;
    logic [7:0]  year;
    rgb_word_t   lcd_rgb_in;
    rgb_word_t   lcd_rgb;
    logic        lcd_rgb_oe;
    logic        lcd_hs;
    logic        lcd_vs;
    logic        lcd_de;
    logic        lcd_bl;
    logic        lcd_clk;
    logic        lcd_rst;
    logic        check_failed;
    logic [31:0] lfsr_state = 32'ha7e0f05a;

    lcd_rgb_char dut0 (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .sec        (sec),
        .min        (min),
        .hour       (hour),
        .day        (day),
        .mon        (mon),
        .year       (year),
        .lcd_rgb_in (lcd_rgb_in),
        .lcd_rgb    (lcd_rgb),
        .lcd_rgb_oe (lcd_rgb_oe),
        .lcd_hs     (lcd_hs),
        .lcd_vs     (lcd_vs),
        .lcd_de     (lcd_de),
        .lcd_bl     (lcd_bl),
        .lcd_clk    (lcd_clk),
        .lcd_rst    (lcd_rst)
    );

    tb_frame_checker chk0 (
        .clk          (sys_clk),
        .rst_n        (rst_n),
        .sec          (sec),
        .min          (min),
        .hour         (hour),
        .day          (day),
        .mon          (mon),
        .year         (year),
        .lcd_rgb_in   (lcd_rgb_in),
        .lcd_rgb      (lcd_rgb),
        .lcd_rgb_oe   (lcd_rgb_oe),
        .lcd_hs       (lcd_hs),
        .lcd_vs       (lcd_vs),
        .lcd_de       (lcd_de),
        .lcd_bl       (lcd_bl),
        .lcd_clk      (lcd_clk),
        .lcd_rst      (lcd_rst),
        .check_failed (check_failed)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [3:0] pick_digit(input int limit);
        return 4'(lfsr_take(4) % limit);
    endfunction

    // Legal BCD only
    task automatic random_time;
        logic [3:0] tens;
        sec     = {pick_digit(6), pick_digit(10)};
        min     = {pick_digit(6), pick_digit(10)};
        tens    = pick_digit(3);
        hour    = {tens, (tens == 4'd2) ? pick_digit(4) : pick_digit(10)};
        tens    = pick_digit(3);
        day     = {tens, 4'd1 + pick_digit(9)};
        tens    = pick_digit(2);
        mon     = {tens, (tens == 4'd1) ? pick_digit(3) : 4'd1 + pick_digit(9)};
        year    = {pick_digit(10), pick_digit(10)};
    endtask

    task automatic run_phase(input logic [2:0] strap);
        @(posedge sys_clk);
        #10;
        rst_n                = 1'b0;
        lcd_rgb_in           = '0;
        lcd_rgb_in.strap.m0  = strap[0];
        lcd_rgb_in.strap.m1  = strap[1];
        lcd_rgb_in.strap.m2  = strap[2];
        random_time();
        repeat (3) @(posedge sys_clk);
        #10 rst_n = 1'b1;
        @(posedge lcd_rst);
        repeat (2) begin
            repeat (21) @(posedge lcd_de);  // Inside the text rows
            #10 random_time();
            @(negedge lcd_vs);
        end
        repeat (2) @(posedge sys_clk);   // Let the frame-end checks run
        #10;
    endtask

    //****************************************
    // Main sequence
    //****************************************
    initial begin
        rst_n      = 1'b0;
        sec        = 8'h00;
        min        = 8'h00;
        hour       = 8'h00;
        day        = 8'h01;
        mon        = 8'h01;
        year       = 8'h00;
        lcd_rgb_in = '0;
        run_phase(3'd0);  // 4.3 inch straps
        run_phase(3'd1);  // 7 inch straps
        if (check_failed) begin
            $display("Result: FAILED");
            $fatal(1, "checks reported errors");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

    initial begin
        @(posedge check_failed);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before both panel phases finished");
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

endmodule

/* time_text/font_8x8.hex */
// One byte per glyph row, MSB is the leftmost pixel
// Eight rows per glyph in code order: 0-9, dash, colon, blank
// 0
3C
66
6E
76
66
66
3C
00
// 1
18
38
18
18
18
18
7E
00
// 2
3C
66
06
0C
30
60
7E
00
// 3
3C
66
06
1C
06
66
3C
00
// 4
0C
1C
3C
6C
7E
0C
0C
00
// 5
7E
60
7C
06
06
66
3C
00
// 6
3C
66
60
7C
66
66
3C
00
// 7
7E
06
0C
18
30
30
30
00
// 8
3C
66
66
3C
66
66
3C
00
// 9
3C
66
66
3E
06
66
3C
00
// dash
00
00
00
7E
00
00
00
00
// colon
00
18
18
00
18
18
00
00
// blank
00
00
00
00
00
00
00
00

/* sources.f */
common/lcd_pkg.sv
verilog/panel_probe.sv
lcd_timing/lcd_timing.sv
time_text/time_text_render.sv
verilog/lcd_output_stage.sv
verilog/lcd_rgb_char.sv
testbench/tb_frame_checker.sv
testbench/tb_lcd_rgb_char.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LCD testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_lcd_rgb_char > sim.log 2>&1 \
    && ./obj_dir/Vtb_lcd_rgb_char >> sim.log 2>&1
grep -q "Result: FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Build or run did not finish, see sim.log"; exit 1; }
echo "Simulation passed"
